// ==== design/rv_isa_pkg.sv ====
`default_nettype none

package rv_isa_pkg;

    // data path width, the lane logic in lsu is built for 64
    localparam int unsigned xlen = 64;

    // major opcodes, instruction bits [6:2]
    localparam logic [4:0] opc_load   = 5'b00000;
    localparam logic [4:0] opc_store  = 5'b01000;
    localparam logic [4:0] opc_system = 5'b11100;

    // memory access sizes in funct3
    localparam logic [2:0] f3_b  = 3'b000;
    localparam logic [2:0] f3_h  = 3'b001;
    localparam logic [2:0] f3_w  = 3'b010;
    localparam logic [2:0] f3_d  = 3'b011;
    localparam logic [2:0] f3_bu = 3'b100;
    localparam logic [2:0] f3_hu = 3'b101;
    localparam logic [2:0] f3_wu = 3'b110;

    // csr register forms in funct3
    localparam logic [2:0] f3_csrrw = 3'b001;
    localparam logic [2:0] f3_csrrs = 3'b010;
    localparam logic [2:0] f3_csrrc = 3'b011;

    // i-type layout, also used by loads and csr instructions
    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } load_fmt_s;

    // s-type layout
    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } store_fmt_s;

    typedef union packed {
        load_fmt_s  ld;
        store_fmt_s st;
    } instr_u;

endpackage

`default_nettype wire

// ==== design/csr_pkg.sv ====
`default_nettype none

package csr_pkg;

    // machine trap setup and handling addresses
    localparam logic [11:0] csr_mtvec    = 12'h305;
    localparam logic [11:0] csr_mscratch = 12'h340;
    localparam logic [11:0] csr_mepc     = 12'h341;

    // default trap vector when the top level sets none
    localparam logic [rv_isa_pkg::xlen-1:0] mtvec_rst_default = 64'h0000_0000_8000_0000;

    // mepc and mscratch come out of reset cleared
    localparam logic [rv_isa_pkg::xlen-1:0] mepc_rst     = '0;
    localparam logic [rv_isa_pkg::xlen-1:0] mscratch_rst = '0;

endpackage

`default_nettype wire

// ==== design/ls_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module ls_ctrl (
    input  logic                          valid_i,
    input  rv_isa_pkg::instr_u            instr_i,
    input  rv_isa_pkg::instr_u            instr_last_i,
    input  logic [rv_isa_pkg::xlen-1:0]   rs2_i,
    input  logic [rv_isa_pkg::xlen-1:0]   wb_data_i,
    output logic                          rd_en_o,
    output logic                          wr_en_o,
    output logic [2:0]                    mem_op_o,
    output logic [rv_isa_pkg::xlen-1:0]   st_data_o
);

    import rv_isa_pkg::*;

    logic last_is_load;
    logic fwd_hit;

    // memory op decode for the current instruction
    assign rd_en_o  = valid_i && (instr_i.ld.opcode[6:2] == opc_load);
    assign wr_en_o  = valid_i && (instr_i.st.opcode[6:2] == opc_store);
    assign mem_op_o = instr_i.ld.funct3;

    // previous load has not reached the register file yet
    assign last_is_load = (instr_last_i.ld.opcode[6:2] == opc_load);
    assign fwd_hit      = last_is_load && (instr_last_i.ld.rd == instr_i.st.rs2);

    // take the load's writeback value as store data on a match
    assign st_data_o = fwd_hit ? wb_data_i : rs2_i;

endmodule

`default_nettype wire

// ==== design/lsu.sv ====
`timescale 1ns/1ns
`default_nettype none

module lsu (
    input  logic                          rd_en_i,
    input  logic                          wr_en_i,
    input  logic [2:0]                    mem_op_i,
    input  logic [rv_isa_pkg::xlen-1:0]   addr_i,
    input  logic [rv_isa_pkg::xlen-1:0]   st_data_i,
    input  logic [rv_isa_pkg::xlen-1:0]   mem_rdata_i,
    output logic [rv_isa_pkg::xlen-1:0]   mem_addr_o,
    output logic                          mem_we_o,
    output logic [rv_isa_pkg::xlen-1:0]   mem_wdata_o,
    output logic [rv_isa_pkg::xlen-1:0]   ld_res_o
);

    import rv_isa_pkg::*;

    localparam int unsigned nbytes = xlen / 8;

    logic [7:0]        byte_lane;
    logic [15:0]       half_lane;
    logic [31:0]       word_lane;
    logic [xlen-1:0]   ld_val;
    logic [nbytes-1:0] lane_mask;
    logic [xlen-1:0]   st_lanes;

    // memory sees the full address, it drops the bits it cannot use
    assign mem_addr_o = addr_i;

    // load lanes
    // bits below the access size are ignored
    assign byte_lane = mem_rdata_i[{addr_i[2:0], 3'b000} +: 8];
    assign half_lane = mem_rdata_i[{addr_i[2:1], 4'b0000} +: 16];
    assign word_lane = mem_rdata_i[{addr_i[2], 5'b00000} +: 32];

    always_comb begin
        case (mem_op_i)
            f3_b: begin
                ld_val = {{(xlen - 8){byte_lane[7]}}, byte_lane};
            end
            f3_bu: begin
                ld_val = {{(xlen - 8){1'b0}}, byte_lane};
            end
            f3_h: begin
                ld_val = {{(xlen - 16){half_lane[15]}}, half_lane};
            end
            f3_hu: begin
                ld_val = {{(xlen - 16){1'b0}}, half_lane};
            end
            f3_w: begin
                ld_val = {{(xlen - 32){word_lane[31]}}, word_lane};
            end
            f3_wu: begin
                ld_val = {{(xlen - 32){1'b0}}, word_lane};
            end
            f3_d: begin
                ld_val = mem_rdata_i;
            end
            default: begin
                ld_val = '0;
            end
        endcase
    end

    // nothing on the result bus without a valid load
    assign ld_res_o = rd_en_i ? ld_val : '0;

    // store byte enables and data copied into every lane
    always_comb begin
        case (mem_op_i)
            f3_b: begin
                lane_mask = 8'b0000_0001 << addr_i[2:0];
                st_lanes  = {nbytes{st_data_i[7:0]}};
            end
            f3_h: begin
                lane_mask = 8'b0000_0011 << {addr_i[2:1], 1'b0};
                st_lanes  = {(nbytes / 2){st_data_i[15:0]}};
            end
            f3_w: begin
                lane_mask = 8'b0000_1111 << {addr_i[2], 2'b00};
                st_lanes  = {(nbytes / 4){st_data_i[31:0]}};
            end
            f3_d: begin
                lane_mask = '1;
                st_lanes  = st_data_i;
            end
            default: begin
                // no valid store size, the old word goes back unchanged
                lane_mask = '0;
                st_lanes  = st_data_i;
            end
        endcase
    end

    // merge the addressed lanes into the old word
    always_comb begin
        for (int b = 0; b < nbytes; b++) begin
            mem_wdata_o[b*8 +: 8] = lane_mask[b] ? st_lanes[b*8 +: 8] : mem_rdata_i[b*8 +: 8];
        end
    end

    assign mem_we_o = wr_en_i;

    // the decoder hands over funct3 as is, stores have no unsigned forms
    always_comb begin
        if (wr_en_i) begin
            a_store_op: assert final (!mem_op_i[2])
                else $error("lsu: store with access code %b", mem_op_i);
        end
    end

endmodule

`default_nettype wire

// ==== design/data_mem.sv ====
`timescale 1ns/1ns
`default_nettype none

module data_mem #(
    parameter int unsigned MEM_DEPTH = 256
) (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  logic                          we_i,
    input  logic [rv_isa_pkg::xlen-1:0]   addr_i,
    input  logic [rv_isa_pkg::xlen-1:0]   wdata_i,
    output logic [rv_isa_pkg::xlen-1:0]   rdata_o
);

    import rv_isa_pkg::*;

    localparam int unsigned aw = $clog2(MEM_DEPTH);

    logic [xlen-1:0] mem [MEM_DEPTH];
    logic [aw-1:0]   word_idx;

    // byte offset dropped, upper bits wrap modulo the depth
    assign word_idx = addr_i[aw+2:3];

    // read is combinational so the store merge sees the current word
    assign rdata_o = mem[word_idx];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < MEM_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (we_i) begin
            mem[word_idx] <= wdata_i;
        end
    end

endmodule

`default_nettype wire

// ==== design/csr_file.sv ====
`timescale 1ns/1ns
`default_nettype none

module csr_file #(
    parameter logic [rv_isa_pkg::xlen-1:0] MTVEC_RESET = csr_pkg::mtvec_rst_default
) (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  logic                          valid_i,
    input  logic                          trap_i,
    input  logic [rv_isa_pkg::xlen-1:0]   pc_i,
    input  rv_isa_pkg::instr_u            instr_i,
    input  logic [rv_isa_pkg::xlen-1:0]   wdata_i,
    output logic [rv_isa_pkg::xlen-1:0]   csr_data_o,
    output logic [rv_isa_pkg::xlen-1:0]   mtvec_o,
    output logic [rv_isa_pkg::xlen-1:0]   mepc_o
);

    import rv_isa_pkg::*;
    import csr_pkg::*;

    logic [xlen-1:0] mtvec_q;
    logic [xlen-1:0] mepc_q;
    logic [xlen-1:0] mscratch_q;
    logic [11:0]     csr_addr;
    logic [2:0]      csr_op;
    logic            is_csr;
    logic            csr_we;
    logic            trap_take;
    logic            mepc_we;
    logic [xlen-1:0] csr_old;
    logic [xlen-1:0] csr_new;

    // csr address sits in the i-type immediate
    assign csr_addr  = instr_i.ld.imm;
    assign csr_op    = instr_i.ld.funct3;
    assign is_csr    = valid_i && (instr_i.ld.opcode[6:2] == opc_system) && (csr_op != 3'b000);
    assign trap_take = valid_i && trap_i;

    // old value, unknown addresses read as zero
    always_comb begin
        case (csr_addr)
            csr_mtvec:    csr_old = mtvec_q;
            csr_mepc:     csr_old = mepc_q;
            csr_mscratch: csr_old = mscratch_q;
            default:      csr_old = '0;
        endcase
    end

    always_comb begin
        csr_we  = is_csr;
        csr_new = csr_old;
        case (csr_op)
            f3_csrrw: csr_new = wdata_i;
            f3_csrrs: csr_new = csr_old | wdata_i;
            f3_csrrc: csr_new = csr_old & ~wdata_i;
            default:  csr_we  = 1'b0;
        endcase
    end

    assign mepc_we = csr_we && (csr_addr == csr_mepc);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mtvec_q    <= MTVEC_RESET;
            mepc_q     <= mepc_rst;
            mscratch_q <= mscratch_rst;
        end else begin
            if (csr_we && (csr_addr == csr_mtvec)) begin
                mtvec_q <= csr_new;
            end
            if (csr_we && (csr_addr == csr_mscratch)) begin
                mscratch_q <= csr_new;
            end
            // trap pc wins over a software write in the same cycle
            if (trap_take) begin
                mepc_q <= pc_i;
            end else if (mepc_we) begin
                mepc_q <= csr_new;
            end
        end
    end

    assign csr_data_o = is_csr ? csr_old : '0;
    assign mtvec_o    = mtvec_q;
    assign mepc_o     = mepc_q;

    // mepc only moves on a trap or its own write
    a_mepc_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        (!trap_take && !mepc_we) |=> $stable(mepc_o))
        else $error("csr_file: mepc changed without trap or write");

endmodule

`default_nettype wire

// ==== design/ls_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module ls_stage #(
    parameter int unsigned                  MEM_DEPTH   = 256,
    parameter logic [rv_isa_pkg::xlen-1:0]  MTVEC_RESET = csr_pkg::mtvec_rst_default
) (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  logic                          valid_i,
    input  logic [rv_isa_pkg::xlen-1:0]   pc_i,
    input  rv_isa_pkg::instr_u            instr_i,
    input  logic [rv_isa_pkg::xlen-1:0]   alu_res_i,
    input  logic [rv_isa_pkg::xlen-1:0]   rs2_i,
    input  rv_isa_pkg::instr_u            instr_last_i,
    input  logic [rv_isa_pkg::xlen-1:0]   wb_data_i,
    input  logic                          trap_i,
    output logic [rv_isa_pkg::xlen-1:0]   ls_res_o,
    output logic [rv_isa_pkg::xlen-1:0]   csr_data_o,
    output logic [rv_isa_pkg::xlen-1:0]   mtvec_o,
    output logic [rv_isa_pkg::xlen-1:0]   mepc_o
);

    import rv_isa_pkg::*;

    logic            rd_en;
    logic            wr_en;
    logic [2:0]      mem_op;
    logic [xlen-1:0] st_data;
    logic [xlen-1:0] mem_addr;
    logic            mem_we;
    logic [xlen-1:0] mem_wdata;
    logic [xlen-1:0] mem_rdata;

    ls_ctrl u_ls_ctrl (
        .valid_i      (valid_i),
        .instr_i      (instr_i),
        .instr_last_i (instr_last_i),
        .rs2_i        (rs2_i),
        .wb_data_i    (wb_data_i),
        .rd_en_o      (rd_en),
        .wr_en_o      (wr_en),
        .mem_op_o     (mem_op),
        .st_data_o    (st_data)
    );

    // alu result carries the effective address
    lsu u_lsu (
        .rd_en_i     (rd_en),
        .wr_en_i     (wr_en),
        .mem_op_i    (mem_op),
        .addr_i      (alu_res_i),
        .st_data_i   (st_data),
        .mem_rdata_i (mem_rdata),
        .mem_addr_o  (mem_addr),
        .mem_we_o    (mem_we),
        .mem_wdata_o (mem_wdata),
        .ld_res_o    (ls_res_o)
    );

    data_mem #(
        .MEM_DEPTH (MEM_DEPTH)
    ) u_data_mem (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .we_i    (mem_we),
        .addr_i  (mem_addr),
        .wdata_i (mem_wdata),
        .rdata_o (mem_rdata)
    );

    // for csr instructions the alu result is the rs1 value
    csr_file #(
        .MTVEC_RESET (MTVEC_RESET)
    ) u_csr_file (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .valid_i    (valid_i),
        .trap_i     (trap_i),
        .pc_i       (pc_i),
        .instr_i    (instr_i),
        .wdata_i    (alu_res_i),
        .csr_data_o (csr_data_o),
        .mtvec_o    (mtvec_o),
        .mepc_o     (mepc_o)
    );

endmodule

`default_nettype wire

// ==== verif/ls_stage_tests.svh ====
`default_nettype none

task automatic reset_state();
    logic [63:0] val;
    compare("mtvec_o", mtvec_o, mtvec_rst_tb);
    compare("mepc_o", mepc_o, 64'h0);
    load_value(64'h0, f3_d, val);
    compare("ls_res_o", val, 64'h0);
    load_value(mem_depth * 8 - 8, f3_d, val);
    compare("ls_res_o", val, 64'h0);
    for (int i = 0; i < 4; i++) begin
        load_expect($urandom_range(mem_depth * 8 - 1, 0), f3_d);
    end
endtask

// every size at every byte offset, random word and data
task automatic store_load_lanes();
    logic [2:0]  sizes [4];
    logic [63:0] addr;
    logic [63:0] data;
    sizes = '{f3_b, f3_h, f3_w, f3_d};
    for (int r = 0; r < 5; r++) begin
        for (int s = 0; s < 4; s++) begin
            for (int off = 0; off < 8; off++) begin
                addr = $urandom_range(mem_depth - 1, 0) * 8 + off;
                data = {$urandom, $urandom};
                store_op(addr, sizes[s], data);
                load_expect(addr, sizes[s]);
                // unsigned form of the same size
                if (sizes[s] != f3_d) begin
                    load_expect(addr, sizes[s] | 3'b100);
                end
                load_expect(addr, f3_d);
            end
        end
    end
endtask

task automatic subword_merge();
    logic [63:0] addr;
    logic [63:0] val;
    addr = $urandom_range(mem_depth - 1, 0) * 8;
    store_op(addr, f3_d, 64'h0123_4567_89ab_cdef);
    store_op(addr + 3, f3_b, 64'h0000_0000_0000_005a);
    store_op(addr + 6, f3_h, 64'hffff_ffff_ffff_beef);
    store_op(addr + 1, f3_b, 64'h0000_0000_0000_ff00);
    // odd address lands in the halfword at offset 4
    store_op(addr + 5, f3_h, 64'h0000_0000_0000_1234);
    load_value(addr, f3_d, val);
    compare("ls_res_o", val, 64'hbeef_1234_5aab_00ef);
    load_expect(addr, f3_d);
endtask

task automatic store_forwarding();
    logic [63:0] addr;
    logic [63:0] res;
    logic [63:0] old;
    addr = $urandom_range(mem_depth - 1, 0) * 8;
    // last load wrote x11, the store reads x11
    issue(store_instr(5'd11, f3_d), load_instr(5'd11, f3_d), addr,
          64'h1111_1111_1111_1111, 64'h2222_2222_2222_2222, 1'b0, 64'h0, res, old);
    model_store(addr, f3_d, 64'h2222_2222_2222_2222);
    load_expect(addr, f3_d);
    issue(store_instr(5'd11, f3_w), load_instr(5'd12, f3_d), addr + 4,
          64'h3333_3333_4444_4444, 64'h5555_5555_5555_5555, 1'b0, 64'h0, res, old);
    model_store(addr + 4, f3_w, 64'h3333_3333_4444_4444);
    load_expect(addr, f3_d);
    // addi x11 is not a load, no forwarding
    issue(store_instr(5'd11, f3_h), {12'h000, 5'd0, 3'b000, 5'd11, 7'b0010011}, addr + 2,
          64'h0000_0000_0000_7777, 64'h0000_0000_0000_8888, 1'b0, 64'h0, res, old);
    model_store(addr + 2, f3_h, 64'h0000_0000_0000_7777);
    load_expect(addr, f3_d);
endtask

task automatic idle_no_effect();
    logic [63:0] addr;
    addr = $urandom_range(mem_depth - 1, 0) * 8;
    store_op(addr, f3_d, 64'h5555_aaaa_0f0f_f0f0);
    @(negedge clk);
    valid_i      = 1'b0;
    instr_i      = store_instr(5'd11, f3_d);
    instr_last_i = nop_instr;
    alu_res_i    = addr;
    rs2_i        = 64'hdead_beef_dead_beef;
    #1;
    compare("ls_res_o", ls_res_o, 64'h0);
    @(negedge clk);
    instr_i = load_instr(5'd10, f3_d);
    #1;
    compare("ls_res_o", ls_res_o, 64'h0);
    load_expect(addr, f3_d);
endtask

// checks the old value, then updates the expected register
task automatic csr_access(input logic [11:0] csr, input logic [2:0] f3,
                          input logic [63:0] wdata, inout logic [63:0] shadow);
    logic [63:0] res;
    logic [63:0] old;
    issue(csr_instr(csr, f3), nop_instr, wdata, 64'h0, 64'h0, 1'b0, 64'h0, res, old);
    compare("csr_data_o", old, shadow);
    case (f3)
        f3_csrrw: shadow = wdata;
        f3_csrrs: shadow = shadow | wdata;
        f3_csrrc: shadow = shadow & ~wdata;
        default:  shadow = shadow;
    endcase
endtask

task automatic csr_access_rules();
    logic [63:0] scratch;
    logic [63:0] tvec;
    logic [63:0] epc;
    logic [63:0] res;
    logic [63:0] old;
    scratch = 64'h0;
    tvec    = mtvec_rst_tb;
    epc     = 64'h0;
    csr_access(csr_mscratch, f3_csrrw, 64'h1234_5678_9abc_def0, scratch);
    csr_access(csr_mscratch, f3_csrrs, 64'h0f00_0000_0000_000f, scratch);
    csr_access(csr_mscratch, f3_csrrc, 64'h1030_0000_0000_00f0, scratch);
    csr_access(csr_mscratch, f3_csrrs, 64'h0, scratch);
    csr_access(csr_mtvec, f3_csrrw, 64'h0000_0000_0000_4000, tvec);
    compare("mtvec_o", mtvec_o, tvec);
    csr_access(csr_mtvec, f3_csrrs, 64'h0000_0000_0000_0103, tvec);
    compare("mtvec_o", mtvec_o, tvec);
    csr_access(csr_mtvec, f3_csrrc, 64'h0000_0000_0000_4001, tvec);
    compare("mtvec_o", mtvec_o, tvec);
    csr_access(csr_mepc, f3_csrrw, 64'h0000_0000_0000_0884, epc);
    compare("mepc_o", mepc_o, epc);
    issue(nop_instr, nop_instr, 64'h0, 64'h0, 64'h0, 1'b1, 64'h0000_0000_0000_2a40, res, old);
    compare("mepc_o", mepc_o, 64'h0000_0000_0000_2a40);
    // trap and software write in one strobe
    issue(csr_instr(csr_mepc, f3_csrrw), nop_instr, 64'hffff_0000_ffff_0000, 64'h0, 64'h0,
          1'b1, 64'h0000_0000_0000_3b7c, res, old);
    compare("csr_data_o", old, 64'h0000_0000_0000_2a40);
    compare("mepc_o", mepc_o, 64'h0000_0000_0000_3b7c);
    // unimplemented address
    issue(csr_instr(12'h7c0, f3_csrrw), nop_instr, 64'h1, 64'h0, 64'h0, 1'b0, 64'h0, res, old);
    compare("csr_data_o", old, 64'h0);
    issue(csr_instr(12'h7c0, f3_csrrs), nop_instr, 64'h0, 64'h0, 64'h0, 1'b0, 64'h0, res, old);
    compare("csr_data_o", old, 64'h0);
endtask

`default_nettype wire

// ==== verif/ls_stage_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module ls_stage_tb;

    import rv_isa_pkg::*;
    import csr_pkg::*;

    localparam int unsigned mem_depth    = 256;
    localparam logic [63:0] mtvec_rst_tb = 64'h0000_0000_0000_1c00;
    // full sequence runs about 1350 cycles
    localparam int          max_cycles   = 3000;
    // addi x0, x0, 0
    localparam logic [31:0] nop_instr    = 32'h0000_0013;

    logic        clk = 1'b0;
    logic        rst_n_i;
    logic        valid_i;
    logic [63:0] pc_i;
    logic [31:0] instr_i;
    logic [63:0] alu_res_i;
    logic [63:0] rs2_i;
    logic [31:0] instr_last_i;
    logic [63:0] wb_data_i;
    logic        trap_i;
    logic [63:0] ls_res_o;
    logic [63:0] csr_data_o;
    logic [63:0] mtvec_o;
    logic [63:0] mepc_o;

    // expected memory contents
    logic [63:0] ref_mem [mem_depth];
    int          err_cnt;
    int          check_cnt;
    int          test_cnt;
    int          cycle_cnt = 0;
    int          base;

    ls_stage #(
        .MEM_DEPTH   (mem_depth),
        .MTVEC_RESET (mtvec_rst_tb)
    ) uut (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .valid_i      (valid_i),
        .pc_i         (pc_i),
        .instr_i      (instr_i),
        .alu_res_i    (alu_res_i),
        .rs2_i        (rs2_i),
        .instr_last_i (instr_last_i),
        .wb_data_i    (wb_data_i),
        .trap_i       (trap_i),
        .ls_res_o     (ls_res_o),
        .csr_data_o   (csr_data_o),
        .mtvec_o      (mtvec_o),
        .mepc_o       (mepc_o)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    initial begin
        wait (cycle_cnt >= max_cycles);
        $display("timeout: the run did not finish within %0d cycles", max_cycles);
        $display("TB FAILED");
        $finish;
    end

    task automatic compare(input string sig, input logic [63:0] got, input logic [63:0] exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("MISMATCH %s: got %h, expected %h at %0t", sig, got, exp, $time);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        test_cnt++;
        if (err_cnt == errs_before) begin
            $display("test %0d %s: pass", test_cnt, name);
        end else begin
            $display("test %0d %s: fail, %0d errors", test_cnt, name, err_cnt - errs_before);
        end
    endtask

    function automatic logic [31:0] load_instr(input logic [4:0] rd, input logic [2:0] f3);
        return {12'h000, 5'd1, f3, rd, opc_load, 2'b11};
    endfunction

    function automatic logic [31:0] store_instr(input logic [4:0] rs2, input logic [2:0] f3);
        return {7'h00, rs2, 5'd1, f3, 5'h00, opc_store, 2'b11};
    endfunction

    function automatic logic [31:0] csr_instr(input logic [11:0] csr, input logic [2:0] f3);
        return {csr, 5'd1, f3, 5'd5, opc_system, 2'b11};
    endfunction

    // sign or zero extended lane, low address bits below the size dropped
    function automatic logic [63:0] model_load(input logic [63:0] addr, input logic [2:0] f3);
        int unsigned nb;
        int unsigned off;
        logic [63:0] keep;
        logic [63:0] val;
        nb   = 1 << f3[1:0];
        off  = (addr[2:0] / nb) * nb;
        keep = (nb == 8) ? ~64'd0 : (64'd1 << (8 * nb)) - 64'd1;
        val  = (ref_mem[(addr >> 3) % mem_depth] >> (8 * off)) & keep;
        if (!f3[2] && val[8 * nb - 1]) begin
            val = val | ~keep;
        end
        return val;
    endfunction

    function automatic void model_store(input logic [63:0] addr, input logic [2:0] f3,
                                        input logic [63:0] data);
        int unsigned nb;
        int unsigned off;
        int unsigned idx;
        nb  = 1 << f3[1:0];
        off = (addr[2:0] / nb) * nb;
        idx = (addr >> 3) % mem_depth;
        for (int i = 0; i < nb; i++) begin
            ref_mem[idx][8 * (off + i) +: 8] = data[8 * i +: 8];
        end
    endfunction

    // one strobe: drive on the falling edge, sample mid low phase, drop valid next fall
    task automatic issue(input logic [31:0] ins, input logic [31:0] last,
                         input logic [63:0] addr, input logic [63:0] rs2,
                         input logic [63:0] wb, input logic trap, input logic [63:0] pc,
                         output logic [63:0] res, output logic [63:0] csr);
        @(negedge clk);
        valid_i      = 1'b1;
        instr_i      = ins;
        instr_last_i = last;
        alu_res_i    = addr;
        rs2_i        = rs2;
        wb_data_i    = wb;
        trap_i       = trap;
        pc_i         = pc;
        #1;
        res = ls_res_o;
        csr = csr_data_o;
        @(negedge clk);
        valid_i = 1'b0;
        trap_i  = 1'b0;
    endtask

    task automatic store_op(input logic [63:0] addr, input logic [2:0] f3,
                            input logic [63:0] data);
        logic [63:0] res;
        logic [63:0] csr;
        issue(store_instr(5'd11, f3), nop_instr, addr, data, 64'h0, 1'b0, 64'h0, res, csr);
        compare("ls_res_o", res, 64'h0);
        model_store(addr, f3, data);
    endtask

    task automatic load_value(input logic [63:0] addr, input logic [2:0] f3,
                              output logic [63:0] val);
        logic [63:0] csr;
        issue(load_instr(5'd10, f3), nop_instr, addr, 64'h0, 64'h0, 1'b0, 64'h0, val, csr);
    endtask

    task automatic load_expect(input logic [63:0] addr, input logic [2:0] f3);
        logic [63:0] val;
        load_value(addr, f3, val);
        compare("ls_res_o", val, model_load(addr, f3));
    endtask

    initial begin
        void'($urandom(32'h953e_c3b8));
        err_cnt      = 0;
        check_cnt    = 0;
        test_cnt     = 0;
        rst_n_i      = 1'b0;
        valid_i      = 1'b0;
        pc_i         = 64'h0;
        instr_i      = nop_instr;
        alu_res_i    = 64'h0;
        rs2_i        = 64'h0;
        instr_last_i = nop_instr;
        wb_data_i    = 64'h0;
        trap_i       = 1'b0;
        for (int i = 0; i < mem_depth; i++) begin
            ref_mem[i] = 64'h0;
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;

        base = err_cnt;
        reset_state();
        report_test("reset state", base);
        base = err_cnt;
        store_load_lanes();
        report_test("store/load lanes", base);
        base = err_cnt;
        subword_merge();
        report_test("sub-word merge", base);
        base = err_cnt;
        store_forwarding();
        report_test("store forwarding", base);
        base = err_cnt;
        idle_no_effect();
        report_test("idle inputs", base);
        base = err_cnt;
        csr_access_rules();
        report_test("csr access", base);

        $display("%0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    `include "ls_stage_tests.svh"

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+verif
design/rv_isa_pkg.sv
design/csr_pkg.sv
design/ls_ctrl.sv
design/lsu.sv
design/data_mem.sv
design/csr_file.sv
design/ls_stage.sv
verif/ls_stage_tb.sv

// ==== Bender.yml ====
package:
  name: ls_stage

sources:
  - design/rv_isa_pkg.sv
  - design/csr_pkg.sv
  - design/ls_ctrl.sv
  - design/lsu.sv
  - design/data_mem.sv
  - design/csr_file.sv
  - design/ls_stage.sv
  - target: simulation
    include_dirs:
      - verif
    files:
      - verif/ls_stage_tb.sv
